/* common/vc_alloc_pkg.sv */
// allocator sizes, packed bus types and the VC numbering helper, imported by RTL and testbench
package vc_alloc_pkg;

   // router geometry
   localparam int num_ports = 5;
   localparam int num_message_classes = 2;
   localparam int num_resource_classes = 2;
   localparam int num_vcs_per_class = 1;

   // four VCs per port with the sizes above
   localparam int num_vcs = num_message_classes * num_resource_classes * num_vcs_per_class;

   // VCs inside one message class
   localparam int num_class_vcs = num_resource_classes * num_vcs_per_class;

   typedef logic [num_ports-1:0] port_vec_t;
   typedef logic [num_vcs-1:0] vc_vec_t;
   typedef logic [num_resource_classes-1:0] rc_vec_t;
   typedef logic [num_class_vcs-1:0] class_vc_vec_t;

   // route of one input VC, seven bits
   typedef struct packed {
      port_vec_t port;
      rc_vec_t   rc;
   } vc_route_t;

   // input port, input VC, output port, class VC of the input VC's message class
   typedef logic [num_ports-1:0][num_vcs-1:0][num_ports-1:0][num_class_vcs-1:0] req_matrix_t;

   // VC number inside a port
   // message class is the slowest field, VC within class the fastest
   function automatic int vc_index(int mc, int rc, int cvc);
      return (mc * num_resource_classes + rc) * num_vcs_per_class + cvc;
   endfunction

endpackage

/* logic/rr_arbiter.sv */
// round-robin arbiter with a registered pointer, advanced when the parent raises update
module rr_arbiter #(
   parameter int num_req = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               update,
   input  logic [num_req-1:0] req,
   output logic [num_req-1:0] gnt
);

   // a single requester still needs a one bit pointer
   localparam int ptr_w = (num_req > 1) ? $clog2(num_req) : 1;

   logic [ptr_w-1:0] ptr;
   logic [ptr_w-1:0] win;
   logic             found;

   // first requester at or above the pointer, wrapping around
   always_comb
   begin : search
      int idx;
      gnt   = '0;
      win   = '0;
      found = 1'b0;
      for (int i = 0; i < num_req; i++)
      begin
         idx = int'(ptr) + i;
         if (idx >= num_req)
            idx = idx - num_req;
         if (!found && req[idx])
         begin
            found    = 1'b1;
            win      = ptr_w'(idx);
            gnt[idx] = 1'b1;
         end
      end
   end

   // pointer moves one past the winner
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ptr <= '0;
      else if (update && found)
      begin
         if (win == ptr_w'(num_req - 1))
            ptr <= '0;
         else
            ptr <= win + 1'b1;
      end
   end

endmodule

/* vc_alloc/vc_req_expand.sv */
// fans each input VC request out to the output VCs of its route port, class and resource classes
module vc_req_expand (
   input  vc_alloc_pkg::vc_vec_t     req_ip_ivc [vc_alloc_pkg::num_ports],
   input  vc_alloc_pkg::vc_route_t   route_ip_ivc
                                        [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   output vc_alloc_pkg::req_matrix_t req_out
);

   import vc_alloc_pkg::*;

   // the last resource class may only move on to itself
   localparam rc_vec_t last_rc_only = rc_vec_t'(1) << (num_resource_classes - 1);

   always_comb
   begin : expand
      int      ivc;
      int      ocv;
      rc_vec_t rc_ok;
      req_out = '0;
      for (int ip = 0; ip < num_ports; ip++)
         for (int mc = 0; mc < num_message_classes; mc++)
            for (int irc = 0; irc < num_resource_classes; irc++)
               for (int icvc = 0; icvc < num_vcs_per_class; icvc++)
               begin
                  ivc = vc_index(mc, irc, icvc);
                  if (irc == num_resource_classes - 1)
                     rc_ok = last_rc_only;
                  else
                     rc_ok = route_ip_ivc[ip][ivc].rc;
                  // output VCs are addressed inside the input VC's message class
                  for (int op = 0; op < num_ports; op++)
                     for (int orc = 0; orc < num_resource_classes; orc++)
                        for (int ocvc = 0; ocvc < num_vcs_per_class; ocvc++)
                        begin
                           ocv = orc * num_vcs_per_class + ocvc;
                           req_out[ip][ivc][op][ocv] = req_ip_ivc[ip][ivc] &
                                                       route_ip_ivc[ip][ivc].port[op] &
                                                       rc_ok[orc];
                        end
               end
   end

endmodule

/* vc_alloc/vc_out_stage.sv */
// output-first stage, each output VC picks an input port then one of its VCs and offers a grant
module vc_out_stage (
   input  logic                      clk,
   input  logic                      rst_n,
   input  vc_alloc_pkg::req_matrix_t req_out,
   input  vc_alloc_pkg::req_matrix_t gnt_in,
   input  vc_alloc_pkg::vc_vec_t     elig_op_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::req_matrix_t gnt_out,
   output vc_alloc_pkg::vc_vec_t     gnt_op_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::port_vec_t   sel_op_ovc_ip
                                        [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   output vc_alloc_pkg::vc_vec_t     sel_op_ovc_ivc
                                        [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);

   import vc_alloc_pkg::*;

   // per output VC, requesting input VCs grouped by input port
   class_vc_vec_t req_ivc  [num_ports][num_vcs][num_ports];
   port_vec_t     req_port [num_ports][num_vcs];
   port_vec_t     gnt_port [num_ports][num_vcs];
   class_vc_vec_t gnt_raw  [num_ports][num_vcs][num_ports];

   // ---------------------------------------------------------
   // request gathering
   // ---------------------------------------------------------
   always_comb
   begin : gather
      int            mc;
      int            cv;
      class_vc_vec_t r;
      for (int op = 0; op < num_ports; op++)
         for (int ovc = 0; ovc < num_vcs; ovc++)
         begin
            mc = ovc / num_class_vcs;
            cv = ovc % num_class_vcs;
            for (int ip = 0; ip < num_ports; ip++)
            begin
               for (int icv = 0; icv < num_class_vcs; icv++)
                  r[icv] = req_out[ip][mc * num_class_vcs + icv][op][cv];
               req_ivc[op][ovc][ip] = r;
               req_port[op][ovc][ip] = |r;
            end
         end
   end

   // ---------------------------------------------------------
   // arbiters, pointers move only on an accepted grant
   // ---------------------------------------------------------
   for (genvar op = 0; op < num_ports; op++)
   begin : g_op
      for (genvar ovc = 0; ovc < num_vcs; ovc++)
      begin : g_ovc
         rr_arbiter #(.num_req(num_ports)) u_port_arb (
            .clk    (clk),
            .rst_n  (rst_n),
            .update (gnt_op_ovc[op][ovc]),
            .req    (req_port[op][ovc]),
            .gnt    (gnt_port[op][ovc])
         );
         for (genvar ip = 0; ip < num_ports; ip++)
         begin : g_ip
            rr_arbiter #(.num_req(num_class_vcs)) u_vc_arb (
               .clk    (clk),
               .rst_n  (rst_n),
               .update (gnt_op_ovc[op][ovc] & gnt_port[op][ovc][ip]),
               .req    (req_ivc[op][ovc][ip]),
               .gnt    (gnt_raw[op][ovc][ip])
            );
         end
      end
   end

   // offers go out only for eligible output VCs; selects stay raw
   always_comb
   begin : offer
      int mc;
      int cv;
      gnt_out = '0;
      for (int op = 0; op < num_ports; op++)
         for (int ovc = 0; ovc < num_vcs; ovc++)
         begin
            mc = ovc / num_class_vcs;
            cv = ovc % num_class_vcs;
            sel_op_ovc_ip[op][ovc] = gnt_port[op][ovc];
            sel_op_ovc_ivc[op][ovc] = '0;
            for (int ip = 0; ip < num_ports; ip++)
               for (int icv = 0; icv < num_class_vcs; icv++)
                  if (gnt_port[op][ovc][ip] && gnt_raw[op][ovc][ip][icv])
                  begin
                     sel_op_ovc_ivc[op][ovc][mc * num_class_vcs + icv] = 1'b1;
                     gnt_out[ip][mc * num_class_vcs + icv][op][cv] = elig_op_ovc[op][ovc];
                  end
         end
   end

   // output VC is granted once the input side took the offer
   always_comb
   begin : accept
      int   mc;
      int   cv;
      logic any;
      for (int op = 0; op < num_ports; op++)
         for (int ovc = 0; ovc < num_vcs; ovc++)
         begin
            mc = ovc / num_class_vcs;
            cv = ovc % num_class_vcs;
            any = 1'b0;
            for (int ip = 0; ip < num_ports; ip++)
               for (int icv = 0; icv < num_class_vcs; icv++)
                  any = any | gnt_in[ip][mc * num_class_vcs + icv][op][cv];
            gnt_op_ovc[op][ovc] = any;
         end
   end

endmodule

/* vc_alloc/vc_in_stage.sv */
// input stage, each input VC accepts one offered output VC per resource class
module vc_in_stage (
   input  logic                      clk,
   input  logic                      rst_n,
   input  vc_alloc_pkg::req_matrix_t gnt_out,
   input  vc_alloc_pkg::vc_vec_t     req_ip_ivc [vc_alloc_pkg::num_ports],
   input  vc_alloc_pkg::vc_route_t   route_ip_ivc
                                        [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   output vc_alloc_pkg::req_matrix_t gnt_in,
   output vc_alloc_pkg::vc_vec_t     gnt_ip_ivc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::vc_vec_t     sel_ip_ivc_ovc
                                        [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);

   import vc_alloc_pkg::*;

   class_vc_vec_t                offer [num_ports][num_vcs];
   logic [num_vcs_per_class-1:0] pick  [num_ports][num_vcs][num_resource_classes];

   // only the routed port can offer, so an OR over ports replaces a mux
   always_comb
   begin : collect
      class_vc_vec_t any;
      for (int ip = 0; ip < num_ports; ip++)
         for (int ivc = 0; ivc < num_vcs; ivc++)
         begin
            any = '0;
            for (int op = 0; op < num_ports; op++)
               any = any | gnt_out[ip][ivc][op];
            offer[ip][ivc] = any & {num_class_vcs{req_ip_ivc[ip][ivc]}};
         end
   end

   // ---------------------------------------------------------
   // one arbiter per input VC and resource class
   // ---------------------------------------------------------
   for (genvar ip = 0; ip < num_ports; ip++)
   begin : g_ip
      for (genvar ivc = 0; ivc < num_vcs; ivc++)
      begin : g_ivc
         for (genvar rc = 0; rc < num_resource_classes; rc++)
         begin : g_rc
            logic [num_vcs_per_class-1:0] rc_offer;
            assign rc_offer = offer[ip][ivc][rc * num_vcs_per_class +: num_vcs_per_class];
            rr_arbiter #(.num_req(num_vcs_per_class)) u_ovc_arb (
               .clk    (clk),
               .rst_n  (rst_n),
               .update (|rc_offer),
               .req    (rc_offer),
               .gnt    (pick[ip][ivc][rc])
            );
         end
      end
   end

   // accepted output VC back onto the route port and into the full VC vector
   always_comb
   begin : spread
      int            mc;
      class_vc_vec_t won;
      for (int ip = 0; ip < num_ports; ip++)
         for (int ivc = 0; ivc < num_vcs; ivc++)
         begin
            mc = ivc / num_class_vcs;
            for (int rc = 0; rc < num_resource_classes; rc++)
               won[rc * num_vcs_per_class +: num_vcs_per_class] = pick[ip][ivc][rc];
            for (int op = 0; op < num_ports; op++)
               gnt_in[ip][ivc][op] = route_ip_ivc[ip][ivc].port[op] ? won : '0;
            sel_ip_ivc_ovc[ip][ivc] = '0;
            sel_ip_ivc_ovc[ip][ivc][mc * num_class_vcs +: num_class_vcs] = won;
            gnt_ip_ivc[ip][ivc] = |won;
         end
   end

endmodule

/* vc_alloc/vc_alloc_top.sv */
// separable output-first VC allocator for a five-port router, top level with plain ports
module vc_alloc_top (
   input  logic                    clk,
   input  logic                    rst_n,
   // request and route per input VC
   input  vc_alloc_pkg::vc_vec_t   req_ip_ivc [vc_alloc_pkg::num_ports],
   input  vc_alloc_pkg::vc_route_t route_ip_ivc
                                      [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   // output VC free for allocation
   input  vc_alloc_pkg::vc_vec_t   elig_op_ovc [vc_alloc_pkg::num_ports],
   // to the input controllers
   output vc_alloc_pkg::vc_vec_t   gnt_ip_ivc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::vc_vec_t   sel_ip_ivc_ovc
                                      [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   // to the output controllers
   output vc_alloc_pkg::vc_vec_t   gnt_op_ovc [vc_alloc_pkg::num_ports],
   output vc_alloc_pkg::port_vec_t sel_op_ovc_ip
                                      [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   output vc_alloc_pkg::vc_vec_t   sel_op_ovc_ivc
                                      [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);

   import vc_alloc_pkg::*;

   req_matrix_t req_out;
   req_matrix_t gnt_out;
   req_matrix_t gnt_in;

   // ---------------------------------------------------------
   // request expansion, then output and input arbitration
   // ---------------------------------------------------------
   vc_req_expand u_req_expand (
      .req_ip_ivc   (req_ip_ivc),
      .route_ip_ivc (route_ip_ivc),
      .req_out      (req_out)
   );

   vc_out_stage u_out_stage (
      .clk            (clk),
      .rst_n          (rst_n),
      .req_out        (req_out),
      .gnt_in         (gnt_in),
      .elig_op_ovc    (elig_op_ovc),
      .gnt_out        (gnt_out),
      .gnt_op_ovc     (gnt_op_ovc),
      .sel_op_ovc_ip  (sel_op_ovc_ip),
      .sel_op_ovc_ivc (sel_op_ovc_ivc)
   );

   vc_in_stage u_in_stage (
      .clk            (clk),
      .rst_n          (rst_n),
      .gnt_out        (gnt_out),
      .req_ip_ivc     (req_ip_ivc),
      .route_ip_ivc   (route_ip_ivc),
      .gnt_in         (gnt_in),
      .gnt_ip_ivc     (gnt_ip_ivc),
      .sel_ip_ivc_ovc (sel_ip_ivc_ovc)
   );

endmodule

/* verification/vc_alloc_sva.sv */
// grant consistency assertions, bound into the allocator top level below
module vc_alloc_sva (
   input logic                    clk,
   input logic                    rst_n,
   input vc_alloc_pkg::vc_vec_t   elig_op_ovc [vc_alloc_pkg::num_ports],
   input vc_alloc_pkg::vc_vec_t   gnt_ip_ivc [vc_alloc_pkg::num_ports],
   input vc_alloc_pkg::vc_vec_t   sel_ip_ivc_ovc
                                     [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs],
   input vc_alloc_pkg::vc_vec_t   gnt_op_ovc [vc_alloc_pkg::num_ports],
   input vc_alloc_pkg::port_vec_t sel_op_ovc_ip
                                     [vc_alloc_pkg::num_ports][vc_alloc_pkg::num_vcs]
);
   timeunit 1ns;
   timeprecision 1ps;

   import vc_alloc_pkg::*;

   // failure count, read from the testbench
   int unsigned sva_failures = 0;

   for (genvar p = 0; p < num_ports; p++)
   begin : g_port
      a_eligible_only: assert property (@(posedge clk) disable iff (!rst_n)
            (gnt_op_ovc[p] & ~elig_op_ovc[p]) == '0)
      else
      begin
         sva_failures++;
         $error("output VC granted while not eligible at port %0d", p);
      end
      for (genvar v = 0; v < num_vcs; v++)
      begin : g_vc
         a_one_input_port: assert property (@(posedge clk) disable iff (!rst_n)
               gnt_op_ovc[p][v] |-> $onehot(sel_op_ovc_ip[p][v]))
         else
         begin
            sva_failures++;
            $error("output VC %0d of port %0d granted without one selected port", v, p);
         end
         a_grant_is_select: assert property (@(posedge clk) disable iff (!rst_n)
               gnt_ip_ivc[p][v] == (|sel_ip_ivc_ovc[p][v]))
         else
         begin
            sva_failures++;
            $error("input VC %0d of port %0d grant disagrees with its select", v, p);
         end
      end
   end

endmodule

bind vc_alloc_top vc_alloc_sva u_sva (.*);

/* verification/tb_vc_alloc.sv */
// testbench for the VC allocator, directed cases then random traffic checked against a model
module tb_vc_alloc;
   timeunit 1ns;
   timeprecision 1ps;

   import vc_alloc_pkg::*;

   localparam int half_period = 20;
   localparam int random_cycles = 400;
   localparam int reset_timeout = 10;

   logic      clk = 1'b0;
   logic      rst_n;
   vc_vec_t   req_ip_ivc     [num_ports];
   vc_route_t route_ip_ivc   [num_ports][num_vcs];
   vc_vec_t   elig_op_ovc    [num_ports];
   vc_vec_t   gnt_ip_ivc     [num_ports];
   vc_vec_t   sel_ip_ivc_ovc [num_ports][num_vcs];
   vc_vec_t   gnt_op_ovc     [num_ports];
   port_vec_t sel_op_ovc_ip  [num_ports][num_vcs];
   vc_vec_t   sel_op_ovc_ivc [num_ports][num_vcs];

   // model outputs and model copies of the output stage pointers
   vc_vec_t   exp_gnt_ip     [num_ports];
   vc_vec_t   exp_sel_ip     [num_ports][num_vcs];
   vc_vec_t   exp_gnt_op     [num_ports];
   port_vec_t exp_sel_op_ip  [num_ports][num_vcs];
   vc_vec_t   exp_sel_op_ivc [num_ports][num_vcs];
   int        port_ptr       [num_ports][num_vcs] = '{default: '{default: 0}};
   int        vc_ptr         [num_ports][num_vcs][num_ports] =
                                '{default: '{default: '{default: 0}}};

   int unsigned value_errors = 0;
   int unsigned other_errors = 0;
   string       test_name = "reset";
   logic [31:0] rng_state = 32'd51;

   vc_alloc_top u_vc_alloc_top (.*);

   always #half_period clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // first requester at or after ptr, wrapping, or -1 when nobody asks
   function automatic int rr_pick(input logic [7:0] req, input int n, input int ptr);
      int idx;
      for (int i = 0; i < n; i++)
      begin
         idx = (ptr + i) % n;
         if (req[idx])
            return idx;
      end
      return -1;
   endfunction

   function automatic void ref_allocate(input vc_vec_t req [num_ports],
                                        input vc_route_t route [num_ports][num_vcs],
                                        input vc_vec_t elig [num_ports]);
      logic          rq    [num_ports][num_vcs][num_ports][num_class_vcs];
      logic          offer [num_ports][num_vcs][num_class_vcs];
      int            pw    [num_ports][num_vcs];
      int            vw    [num_ports][num_vcs];
      logic [7:0]    preq;
      logic [7:0]    vreq;
      rc_vec_t       rc_ok;
      int            mc;
      int            cv;
      int            base;
      for (int ip = 0; ip < num_ports; ip++)
         for (int ivc = 0; ivc < num_vcs; ivc++)
         begin
            // a VC of the last resource class may only go on to the last class
            if ((ivc % num_class_vcs) / num_vcs_per_class == num_resource_classes - 1)
               rc_ok = rc_vec_t'(1) << (num_resource_classes - 1);
            else
               rc_ok = route[ip][ivc].rc;
            for (int op = 0; op < num_ports; op++)
               for (int c = 0; c < num_class_vcs; c++)
               begin
                  rq[ip][ivc][op][c] = req[ip][ivc] & route[ip][ivc].port[op] &
                                       rc_ok[c / num_vcs_per_class];
                  offer[ip][ivc][c] = 1'b0;
               end
         end
      // output stage, input port first, then a VC of that port
      for (int op = 0; op < num_ports; op++)
         for (int ovc = 0; ovc < num_vcs; ovc++)
         begin
            mc = ovc / num_class_vcs;
            cv = ovc % num_class_vcs;
            base = mc * num_class_vcs;
            preq = '0;
            for (int ip = 0; ip < num_ports; ip++)
               for (int c = 0; c < num_class_vcs; c++)
                  preq[ip] = preq[ip] | rq[ip][base + c][op][cv];
            pw[op][ovc] = rr_pick(preq, num_ports, port_ptr[op][ovc]);
            vw[op][ovc] = -1;
            exp_sel_op_ip[op][ovc] = '0;
            exp_sel_op_ivc[op][ovc] = '0;
            if (pw[op][ovc] >= 0)
            begin
               vreq = '0;
               for (int c = 0; c < num_class_vcs; c++)
                  vreq[c] = rq[pw[op][ovc]][base + c][op][cv];
               vw[op][ovc] = rr_pick(vreq, num_class_vcs, vc_ptr[op][ovc][pw[op][ovc]]);
               exp_sel_op_ip[op][ovc][pw[op][ovc]] = 1'b1;
               exp_sel_op_ivc[op][ovc][base + vw[op][ovc]] = 1'b1;
               if (elig[op][ovc])
                  offer[pw[op][ovc]][base + vw[op][ovc]][cv] = 1'b1;
            end
         end
      // input stage, one VC per class so each offered class is simply taken
      for (int op = 0; op < num_ports; op++)
         exp_gnt_op[op] = '0;
      for (int ip = 0; ip < num_ports; ip++)
         for (int ivc = 0; ivc < num_vcs; ivc++)
         begin
            base = (ivc / num_class_vcs) * num_class_vcs;
            exp_gnt_ip[ip][ivc] = 1'b0;
            exp_sel_ip[ip][ivc] = '0;
            for (int c = 0; c < num_class_vcs; c++)
               if (offer[ip][ivc][c])
               begin
                  exp_gnt_ip[ip][ivc] = 1'b1;
                  exp_sel_ip[ip][ivc][base + c] = 1'b1;
                  for (int op = 0; op < num_ports; op++)
                     if (route[ip][ivc].port[op])
                        exp_gnt_op[op][base + c] = 1'b1;
               end
         end
      // pointers step past the winner once the grant was accepted
      for (int op = 0; op < num_ports; op++)
         for (int ovc = 0; ovc < num_vcs; ovc++)
            if (exp_gnt_op[op][ovc] && pw[op][ovc] >= 0)
            begin
               port_ptr[op][ovc] = (pw[op][ovc] + 1) % num_ports;
               vc_ptr[op][ovc][pw[op][ovc]] = (vw[op][ovc] + 1) % num_class_vcs;
            end
   endfunction

   task automatic check_vc_vec(input string name, input vc_vec_t expected, input vc_vec_t actual);
      if (actual !== expected)
      begin
         value_errors++;
         $display("Error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic check_port_vec(input string name, input port_vec_t expected,
                                 input port_vec_t actual);
      if (actual !== expected)
      begin
         value_errors++;
         $display("Error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic compare_cycle();
      ref_allocate(req_ip_ivc, route_ip_ivc, elig_op_ovc);
      for (int p = 0; p < num_ports; p++)
      begin
         check_vc_vec($sformatf("%s gnt_ip_ivc[%0d]", test_name, p), exp_gnt_ip[p],
                      gnt_ip_ivc[p]);
         check_vc_vec($sformatf("%s gnt_op_ovc[%0d]", test_name, p), exp_gnt_op[p],
                      gnt_op_ovc[p]);
         for (int v = 0; v < num_vcs; v++)
         begin
            check_vc_vec($sformatf("%s sel_ip_ivc_ovc[%0d][%0d]", test_name, p, v),
                         exp_sel_ip[p][v], sel_ip_ivc_ovc[p][v]);
            check_port_vec($sformatf("%s sel_op_ovc_ip[%0d][%0d]", test_name, p, v),
                           exp_sel_op_ip[p][v], sel_op_ovc_ip[p][v]);
            check_vc_vec($sformatf("%s sel_op_ovc_ivc[%0d][%0d]", test_name, p, v),
                         exp_sel_op_ivc[p][v], sel_op_ovc_ivc[p][v]);
         end
      end
   endtask

   // model and DUT compared just before every rising edge
   always
   begin
      @(negedge clk);
      #(half_period - 1);
      if (rst_n === 1'b1)
         compare_cycle();
   end

   task automatic clear_inputs();
      for (int p = 0; p < num_ports; p++)
      begin
         req_ip_ivc[p] = '0;
         elig_op_ovc[p] = '1;
         for (int v = 0; v < num_vcs; v++)
            route_ip_ivc[p][v] = '0;
      end
   endtask

   task automatic set_request(input int ip, input int ivc, input int op, input rc_vec_t rc);
      req_ip_ivc[ip][ivc] = 1'b1;
      route_ip_ivc[ip][ivc].port = port_vec_t'(1) << op;
      route_ip_ivc[ip][ivc].rc = rc;
   endtask

   task automatic start_step(input string name);
      @(negedge clk);
      test_name = name;
      clear_inputs();
   endtask

   task automatic drive_random();
      for (int p = 0; p < num_ports; p++)
      begin
         rng_state = xorshift(rng_state);
         elig_op_ovc[p] = vc_vec_t'(rng_state[3:0] | rng_state[7:4]);
         for (int v = 0; v < num_vcs; v++)
         begin
            rng_state = xorshift(rng_state);
            req_ip_ivc[p][v] = rng_state[0];
            route_ip_ivc[p][v].rc = rng_state[5:4];
            route_ip_ivc[p][v].port = port_vec_t'(1) << (rng_state[23:8] % num_ports);
         end
      end
   endtask

   // ------------------------------------------------------------
   // directed cases on output ports with known pointer state
   // ------------------------------------------------------------
   task automatic run_tests();
      start_step("single_request");
      set_request(0, 0, 1, 2'b01);
      #(half_period - 1);
      check_vc_vec("single_request gnt_ip", 4'b0001, gnt_ip_ivc[0]);
      check_vc_vec("single_request sel_ip", 4'b0001, sel_ip_ivc_ovc[0][0]);
      check_vc_vec("single_request gnt_op", 4'b0001, gnt_op_ovc[1]);
      check_port_vec("single_request sel_op_ip", 5'b00001, sel_op_ovc_ip[1][0]);
      check_vc_vec("single_request sel_op_ivc", 4'b0001, sel_op_ovc_ivc[1][0]);

      start_step("not_eligible");
      set_request(0, 0, 1, 2'b01);
      elig_op_ovc[1] = 4'b1110;
      #(half_period - 1);
      check_vc_vec("not_eligible gnt_ip", 4'b0000, gnt_ip_ivc[0]);
      check_vc_vec("not_eligible gnt_op", 4'b0000, gnt_op_ovc[1]);

      // ports 1 and 3 share output VC 0 of port 2, port 1 wins first from reset
      for (int i = 0; i < 4; i++)
      begin
         start_step("round_robin");
         set_request(1, 0, 2, 2'b01);
         set_request(3, 0, 2, 2'b01);
         #(half_period - 1);
         check_port_vec("round_robin sel_op_ip", (i % 2 == 0) ? 5'b00010 : 5'b01000,
                        sel_op_ovc_ip[2][0]);
         check_vc_vec("round_robin gnt_ip1", (i % 2 == 0) ? 4'b0001 : 4'b0000, gnt_ip_ivc[1]);
         check_vc_vec("round_robin gnt_ip3", (i % 2 == 0) ? 4'b0000 : 4'b0001, gnt_ip_ivc[3]);
      end

      start_step("message_classes");
      set_request(0, 0, 3, 2'b01);
      set_request(4, 2, 3, 2'b01);
      #(half_period - 1);
      check_vc_vec("message_classes sel_ip0", 4'b0001, sel_ip_ivc_ovc[0][0]);
      check_vc_vec("message_classes sel_ip4", 4'b0100, sel_ip_ivc_ovc[4][2]);
      check_vc_vec("message_classes gnt_op", 4'b0101, gnt_op_ovc[3]);

      start_step("last_class");
      set_request(2, 1, 4, 2'b11);
      #(half_period - 1);
      check_vc_vec("last_class sel_ip", 4'b0010, sel_ip_ivc_ovc[2][1]);
      check_vc_vec("last_class gnt_op", 4'b0010, gnt_op_ovc[4]);

      start_step("random");
      for (int c = 0; c < random_cycles; c++)
      begin
         drive_random();
         @(negedge clk);
      end
      clear_inputs();
      @(negedge clk);
   endtask

   task automatic finish_run();
      int unsigned sva_errors;
      sva_errors = u_vc_alloc_top.u_sva.sva_failures;
      $display("errors: %0d value mismatches, %0d assertion failures, %0d other failures",
               value_errors, sva_errors, other_errors);
      if (value_errors + sva_errors + other_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   initial
   begin
      rst_n = 1'b0;
      clear_inputs();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

   initial
   begin
      for (int n = 0; n < reset_timeout && rst_n !== 1'b1; n++)
         @(negedge clk);
      if (rst_n !== 1'b1)
      begin
         other_errors++;
         $display("reset was not released within %0d cycles", reset_timeout);
         finish_run();
      end
      else
      begin
         run_tests();
         finish_run();
      end
   end

endmodule

/* files.f */
common/vc_alloc_pkg.sv
logic/rr_arbiter.sv
vc_alloc/vc_req_expand.sv
vc_alloc/vc_out_stage.sv
vc_alloc/vc_in_stage.sv
vc_alloc/vc_alloc_top.sv
verification/vc_alloc_sva.sv
verification/tb_vc_alloc.sv

/* Bender.yml */
package:
  name: vc_alloc

sources:
  - common/vc_alloc_pkg.sv
  - logic/rr_arbiter.sv
  - vc_alloc/vc_req_expand.sv
  - vc_alloc/vc_out_stage.sv
  - vc_alloc/vc_in_stage.sv
  - vc_alloc/vc_alloc_top.sv
  - target: test
    files:
      - verification/vc_alloc_sva.sv
      - verification/tb_vc_alloc.sv
